// ==== src/corr_geom_pkg.sv ====
`default_nettype none

package corr_geom_pkg;

	localparam int num_inputs = 4;
	localparam int lag_cross = 3;
	localparam int lag_auto = 2;
	localparam int history_len = 3;
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int integ_samples = 64;
	localparam int num_cross_words = num_baselines * lag_cross;
	localparam int num_auto_words = num_inputs * lag_auto;
	localparam int auto_base = num_cross_words;

	typedef logic [num_inputs-1:0] sample_vec_t;
	typedef logic [num_inputs-1:0] line_mask_t;
	typedef logic [15:0] count_t;
	typedef logic [5:0] frame_cnt_t;

	// now is the newest sample, d2 the oldest one kept.
	typedef struct packed {
		sample_vec_t now;
		sample_vec_t d1;
		sample_vec_t d2;
	} taps_t;

	// sample vector seen lag strobes ago.
	function automatic sample_vec_t tap_vec(taps_t t, int lag);
		case (lag)
			0: return t.now;
			1: return t.d1;
			history_len - 1: return t.d2;
			default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== src/result_bus_pkg.sv ====
`default_nettype none

package result_bus_pkg;

	import corr_geom_pkg::*;

	localparam int ram_depth = 32;

	typedef logic [4:0] addr_t;

	// one word of an engine dump.
	typedef struct packed {
		logic req;
		addr_t addr;
		count_t data;
		logic last;
	} result_wr_t;

endpackage

`default_nettype wire

// ==== src/input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_stage
	import corr_geom_pkg::*;
(
	input wire logic pllclk,
	input wire logic reset,
	input wire sample_vec_t adc_bits,
	input wire logic smp_strobe,
	output taps_t taps,
	output logic sample_en,
	output logic frame_last
);

	frame_cnt_t frame_cnt;

	// history shifts one place per strobe and runs on across frames.
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			taps <= '0;
		end else if (smp_strobe) begin
			taps.now <= adc_bits;
			taps.d1 <= taps.now;
			taps.d2 <= taps.d1;
		end
	end

	// counter wraps by itself after integ_samples strobes.
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			frame_cnt <= '0;
			sample_en <= 1'b0;
			frame_last <= 1'b0;
		end else begin
			sample_en <= smp_strobe;
			frame_last <= smp_strobe && (frame_cnt == frame_cnt_t'(integ_samples - 1));
			if (smp_strobe) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/cross_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module cross_engine
	import corr_geom_pkg::*, result_bus_pkg::*;
(
	input wire logic pllclk,
	input wire logic reset,
	input wire taps_t taps,
	input wire logic sample_en,
	input wire logic frame_last,
	input wire line_mask_t line_mask,
	output result_wr_t wr,
	input wire logic grant
);

	typedef enum logic {
		st_idle,
		st_dump
	} cross_state_t;

	cross_state_t state;
	addr_t word_idx;
	logic [num_cross_words-1:0] hit;
	count_t live [num_cross_words];
	count_t snap [num_cross_words];

	// word order is baseline by baseline, lag 0 to 2 inside each.
	always_comb begin
		int w;
		sample_vec_t dv;
		w = 0;
		hit = '0;
		for (int a = 0; a < num_inputs; a++) begin
			for (int b = a + 1; b < num_inputs; b++) begin
				for (int lag = 0; lag < lag_cross; lag++) begin
					dv = tap_vec(taps, lag);
					hit[w] = sample_en && !line_mask[a] && !line_mask[b] &&
						(taps.now[a] == dv[b]);
					w++;
				end
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int i = 0; i < num_cross_words; i++) begin
				live[i] <= '0;
			end
		end else if (sample_en) begin
			for (int i = 0; i < num_cross_words; i++) begin
				live[i] <= frame_last ? '0 : live[i] + count_t'(hit[i]);
			end
		end
	end

	// snapshot includes the closing sample of the frame.
	always_ff @(posedge pllclk) begin
		if (sample_en && frame_last) begin
			for (int i = 0; i < num_cross_words; i++) begin
				snap[i] <= live[i] + count_t'(hit[i]);
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= st_idle;
			word_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (sample_en && frame_last) begin
						state <= st_dump;
						word_idx <= '0;
					end
				end
				st_dump: begin
					if (grant) begin
						if (wr.last) begin
							state <= st_idle;
						end
						word_idx <= word_idx + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_comb begin
		wr.req = (state == st_dump);
		wr.addr = word_idx;
		wr.data = snap[word_idx];
		wr.last = (word_idx == addr_t'(num_cross_words - 1));
	end

	no_frame_during_dump: assert property (
		@(posedge pllclk) disable iff (!reset)
		frame_last |-> state == st_idle
	);

endmodule

`default_nettype wire

// ==== src/auto_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module auto_engine
	import corr_geom_pkg::*, result_bus_pkg::*;
(
	input wire logic pllclk,
	input wire logic reset,
	input wire taps_t taps,
	input wire logic sample_en,
	input wire logic frame_last,
	input wire line_mask_t line_mask,
	output result_wr_t wr,
	input wire logic grant
);

	typedef enum logic {
		st_idle,
		st_dump
	} auto_state_t;

	auto_state_t state;
	addr_t word_idx;
	logic [num_auto_words-1:0] hit;
	count_t live [num_auto_words];
	count_t snap [num_auto_words];

	// two words per input, lag 1 then lag 2.
	always_comb begin
		sample_vec_t dv;
		hit = '0;
		for (int i = 0; i < num_inputs; i++) begin
			for (int lag = 1; lag <= lag_auto; lag++) begin
				dv = tap_vec(taps, lag);
				hit[i*lag_auto + lag - 1] = sample_en && !line_mask[i] &&
					(taps.now[i] == dv[i]);
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int i = 0; i < num_auto_words; i++) begin
				live[i] <= '0;
			end
		end else if (sample_en) begin
			for (int i = 0; i < num_auto_words; i++) begin
				live[i] <= frame_last ? '0 : live[i] + count_t'(hit[i]);
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (sample_en && frame_last) begin
			for (int i = 0; i < num_auto_words; i++) begin
				snap[i] <= live[i] + count_t'(hit[i]);
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= st_idle;
			word_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (sample_en && frame_last) begin
						state <= st_dump;
						word_idx <= '0;
					end
				end
				st_dump: begin
					if (grant) begin
						if (wr.last) begin
							state <= st_idle;
						end
						word_idx <= word_idx + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// auto words sit after the cross block.
	always_comb begin
		wr.req = (state == st_dump);
		wr.addr = addr_t'(auto_base) + word_idx;
		wr.data = snap[word_idx[2:0]];
		wr.last = (word_idx == addr_t'(num_auto_words - 1));
	end

	no_frame_during_dump: assert property (
		@(posedge pllclk) disable iff (!reset)
		frame_last |-> state == st_idle
	);

endmodule

`default_nettype wire

// ==== src/result_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_arbiter
	import result_bus_pkg::*;
(
	input wire logic pllclk,
	input wire logic reset,
	input wire result_wr_t cross_wr,
	input wire result_wr_t auto_wr,
	output logic cross_grant,
	output logic auto_grant,
	output result_wr_t ram_wr,
	output logic frame_done
);

	logic auto_served;
	logic cross_done;
	logic auto_done;
	logic cross_end;
	logic auto_end;

	// on a tie the engine not served last wins.
	always_comb begin
		cross_grant = cross_wr.req && (!auto_wr.req || auto_served);
		auto_grant = auto_wr.req && (!cross_wr.req || !auto_served);
		ram_wr = cross_grant ? cross_wr : auto_wr;
		ram_wr.req = cross_grant || auto_grant;
		cross_end = cross_grant && cross_wr.last;
		auto_end = auto_grant && auto_wr.last;
	end

	// auto_served starts set so cross goes first.
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			auto_served <= 1'b1;
			cross_done <= 1'b0;
			auto_done <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			if (cross_grant) begin
				auto_served <= 1'b0;
			end else if (auto_grant) begin
				auto_served <= 1'b1;
			end
			frame_done <= 1'b0;
			if ((cross_done || cross_end) && (auto_done || auto_end)) begin
				frame_done <= 1'b1;
				cross_done <= 1'b0;
				auto_done <= 1'b0;
			end else begin
				cross_done <= cross_done || cross_end;
				auto_done <= auto_done || auto_end;
			end
		end
	end

	// a waiting engine keeps the same word until it is taken.
	held_request: assert property (
		@(posedge pllclk) disable iff (!reset)
		(cross_wr.req && !cross_grant) |=> (cross_wr.req && $stable(cross_wr.addr))
	);

endmodule

`default_nettype wire

// ==== src/result_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_ram
	import corr_geom_pkg::*, result_bus_pkg::*;
(
	input wire logic pllclk,
	input wire result_wr_t ram_wr,
	input wire addr_t rd_addr,
	output count_t rd_data
);

	count_t mem [ram_depth];

	always_ff @(posedge pllclk) begin
		if (ram_wr.req) begin
			mem[ram_wr.addr] <= ram_wr.data;
		end
	end

	// one cycle read latency.
	always_ff @(posedge pllclk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module correlator
	import corr_geom_pkg::*, result_bus_pkg::*;
(
	input wire logic pllclk,
	input wire logic reset,
	input wire sample_vec_t adc_bits,
	input wire logic smp_strobe,
	input wire line_mask_t line_mask,
	input wire addr_t rd_addr,
	output count_t rd_data,
	output logic frame_done
);

	taps_t taps;
	logic sample_en;
	logic frame_last;
	result_wr_t cross_wr;
	result_wr_t auto_wr;
	result_wr_t ram_wr;
	logic cross_grant;
	logic auto_grant;

	input_stage stage0 (
		.pllclk(pllclk),
		.reset(reset),
		.adc_bits(adc_bits),
		.smp_strobe(smp_strobe),
		.taps(taps),
		.sample_en(sample_en),
		.frame_last(frame_last)
	);

	cross_engine cross0 (
		.pllclk(pllclk),
		.reset(reset),
		.taps(taps),
		.sample_en(sample_en),
		.frame_last(frame_last),
		.line_mask(line_mask),
		.wr(cross_wr),
		.grant(cross_grant)
	);

	auto_engine auto0 (
		.pllclk(pllclk),
		.reset(reset),
		.taps(taps),
		.sample_en(sample_en),
		.frame_last(frame_last),
		.line_mask(line_mask),
		.wr(auto_wr),
		.grant(auto_grant)
	);

	result_arbiter arb0 (
		.pllclk(pllclk),
		.reset(reset),
		.cross_wr(cross_wr),
		.auto_wr(auto_wr),
		.cross_grant(cross_grant),
		.auto_grant(auto_grant),
		.ram_wr(ram_wr),
		.frame_done(frame_done)
	);

	result_ram ram0 (
		.pllclk(pllclk),
		.ram_wr(ram_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic pllclk
);

	// 8 ns period.
	localparam int half_period = 4;

	initial begin
		pllclk = 1'b0;
		forever begin
			#half_period pllclk = ~pllclk;
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_correlator
	import corr_geom_pkg::*, result_bus_pkg::*;
();

	localparam int reset_cycles = 8;
	localparam int num_frames = 4;
	localparam int num_words = num_cross_words + num_auto_words;
	// worst frame is every strobe followed by 3 idle cycles, then dump and readout.
	localparam int frame_cycles = integ_samples * 4 + 64;
	localparam int timeout_cycles = reset_cycles + num_frames * frame_cycles + 400;

	logic pllclk;
	logic reset;
	sample_vec_t adc_bits;
	logic smp_strobe;
	line_mask_t line_mask;
	addr_t rd_addr;
	count_t rd_data;
	logic frame_done;

	logic [31:0] lfsr_state = 32'h7f267871;
	sample_vec_t hist [history_len] = '{default: '0};
	int live_cnt [num_words] = '{default: 0};
	int expected [num_words] = '{default: 0};
	int frames_sent = 0;
	int done_count = 0;
	int cycle_count = 0;

	tb_clock clk0 (
		.pllclk(pllclk)
	);

	correlator dut0 (
		.pllclk(pllclk),
		.reset(reset),
		.adc_bits(adc_bits),
		.smp_strobe(smp_strobe),
		.line_mask(line_mask),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.frame_done(frame_done)
	);

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	// inputs change 1 ns after the rising edge.
	task automatic step_cycle();
		@(posedge pllclk);
		#1;
	endtask

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic logic [31:0] lfsr_bits(int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_bit()};
		end
		return value;
	endfunction

	// hist[k] is the vector k strobes old.
	task automatic model_strobe(sample_vec_t bits, line_mask_t m);
		int w;
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = bits;
		w = 0;
		for (int a = 0; a < num_inputs; a++) begin
			for (int b = a + 1; b < num_inputs; b++) begin
				for (int lag = 0; lag < lag_cross; lag++) begin
					if (!m[a] && !m[b] && hist[0][a] == hist[lag][b]) begin
						live_cnt[w]++;
					end
					w++;
				end
			end
		end
		for (int i = 0; i < num_inputs; i++) begin
			for (int lag = 1; lag <= lag_auto; lag++) begin
				if (!m[i] && hist[0][i] == hist[lag][i]) begin
					live_cnt[auto_base + i * lag_auto + lag - 1]++;
				end
			end
		end
	endtask

	task automatic run_frame(line_mask_t first_mask, line_mask_t second_mask, int change_at);
		sample_vec_t bits;
		int gap;
		line_mask = first_mask;
		for (int s = 0; s < integ_samples; s++) begin
			// one quiet cycle so the previous sample still counts with the old mask.
			if (s == change_at) begin
				smp_strobe = 1'b0;
				step_cycle();
				line_mask = second_mask;
			end
			bits = sample_vec_t'(lfsr_bits(num_inputs));
			gap = int'(lfsr_bits(2));
			adc_bits = bits;
			smp_strobe = 1'b1;
			model_strobe(bits, line_mask);
			step_cycle();
			repeat (gap) begin
				smp_strobe = 1'b0;
				step_cycle();
			end
		end
		smp_strobe = 1'b0;
		for (int i = 0; i < num_words; i++) begin
			expected[i] = live_cnt[i];
			live_cnt[i] = 0;
		end
		frames_sent++;
	endtask

	// back-to-back reads, each word checked one cycle after its address.
	task automatic check_results(int frame);
		step_cycle();
		rd_addr = '0;
		for (int a = 1; a <= num_words; a++) begin
			step_cycle();
			assert (rd_data == count_t'(expected[a-1])) else
				stop_on_error($sformatf("Fail at time %0t: frame %0d address %0d read %0d, expected %0d",
					$time, frame, a - 1, rd_data, expected[a-1]));
			if (a < num_words) begin
				rd_addr = addr_t'(a);
			end
		end
	endtask

	always @(posedge pllclk) begin
		cycle_count++;
		if (frame_done) begin
			done_count++;
		end
		if (cycle_count >= timeout_cycles) begin
			stop_on_error("timeout: the run did not finish within the cycle limit");
		end
	end

	done_after_frame: assert property (
		@(posedge pllclk) disable iff (!reset)
		frame_done |-> done_count < frames_sent
	) else stop_on_error("frame_done pulsed before a full frame of 64 strobes was sent");

	done_one_cycle: assert property (
		@(posedge pllclk) disable iff (!reset)
		frame_done |=> !frame_done
	) else stop_on_error("frame_done stayed high for more than one cycle");

	initial begin
		line_mask_t first_mask;
		line_mask_t second_mask;
		int change_at;
		reset = 1'b0;
		adc_bits = '0;
		smp_strobe = 1'b0;
		line_mask = '0;
		rd_addr = '0;
		repeat (reset_cycles) step_cycle();
		reset = 1'b1;
		step_cycle();
		for (int f = 0; f < num_frames; f++) begin
			change_at = -1;
			second_mask = '0;
			case (f)
				0, 1: first_mask = '0;
				// line 2 blanked for the whole frame.
				2: first_mask = 4'b0100;
				default: begin
					first_mask = line_mask_t'(lfsr_bits(num_inputs));
					second_mask = ~first_mask;
					change_at = integ_samples / 2;
				end
			endcase
			run_frame(first_mask, second_mask, change_at);
			while (done_count < frames_sent) begin
				step_cycle();
			end
			check_results(f);
		end
		repeat (16) step_cycle();
		if (done_count == num_frames) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_on_error($sformatf("saw %0d frame_done pulses instead of %0d",
				done_count, num_frames));
		end
	end

endmodule

`default_nettype wire

// ==== correlator.f ====
src/corr_geom_pkg.sv
src/result_bus_pkg.sv
src/input_stage.sv
src/cross_engine.sv
src/auto_engine.sv
src/result_arbiter.sv
src/result_ram.sv
src/correlator.sv
verif/tb_clock.sv
verif/tb_correlator.sv
